// File: source/host_mem_pkg.sv
// Host memory map package
// Shared widths, sizes and transfer structs for the read path adapter
`default_nettype none

package host_mem_pkg;

    // Reorder buffer depth, which is also the total number of read credits
    localparam int ROB_ENTRIES = 32;

    // Host bursts may carry at most this many lines and never cross a block of this size
    localparam int HOST_BURST_LINES = 4;

    // Address bits that select a line inside one aligned host block
    localparam int BLOCK_BITS = $clog2(HOST_BURST_LINES);

    typedef logic [25:0] line_addr_t;
    typedef logic [3:0]  burst_len_t;
    typedef logic [3:0]  src_id_t;
    typedef logic [4:0]  rob_idx_t;
    typedef logic [63:0] line_data_t;

    // Line count of a whole source request, 1 to 16
    typedef logic [4:0] req_lines_t;

    // Free credit count, 0 to ROB_ENTRIES inclusive
    typedef logic [5:0] credit_t;

    // Read request from the accelerator, len is the line count minus one
    typedef struct packed {
        line_addr_t addr;
        burst_len_t len;
        src_id_t    id;
    } src_req_t;

    // Burst issued to the host, tag is the reorder buffer slot of the first line
    typedef struct packed {
        line_addr_t addr;
        burst_len_t len;
        rob_idx_t   tag;
    } host_req_t;

    // One line returned by the host, tagged with its own slot
    typedef struct packed {
        rob_idx_t   tag;
        line_data_t data;
    } host_rsp_t;

    // One line returned to the accelerator in request order
    typedef struct packed {
        src_id_t    id;
        line_data_t data;
        logic       last;
    } src_rsp_t;

    // Aligned burst passed from the mapper to the credit gate
    // Lines holds the true count, len the count minus one
    typedef struct packed {
        line_addr_t addr;
        burst_len_t len;
        src_id_t    id;
        logic       last;
        burst_len_t lines;
    } burst_t;

endpackage

`default_nettype wire

// File: source/burst_mapper.sv
// Burst mapper
// Splits each source read request into host bursts inside aligned 4-line blocks
`default_nettype none

module burst_mapper
    import host_mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire src_req_t src_req,
    input  wire logic     src_req_valid,
    output logic          src_req_ready,
    output burst_t        burst,
    output logic          burst_valid,
    input  wire logic     burst_ready
);

    // Address and line count still to be issued after the burst on the output
    line_addr_t next_addr;
    req_lines_t rem_lines;

    // Inputs to the splitter, either a fresh request or the held remainder
    line_addr_t sel_addr;
    req_lines_t sel_rem;
    src_id_t    sel_id;
    burst_t     nxt_burst;

    logic load;
    logic take;

    // Cut one burst from the front of a run of lines
    function automatic burst_t split(line_addr_t addr, req_lines_t rem, src_id_t id);
        req_lines_t room;
        burst_t     b;
        // Lines left before the next aligned block boundary
        room = req_lines_t'(HOST_BURST_LINES) - req_lines_t'(addr[BLOCK_BITS-1:0]);
        b.addr  = addr;
        b.id    = id;
        b.lines = (rem < room) ? burst_len_t'(rem) : burst_len_t'(room);
        b.len   = b.lines - 1'b1;
        // The burst that uses up every remaining line closes the request
        b.last  = (req_lines_t'(b.lines) == rem);
        return b;
    endfunction

    // The mapper takes a new request only while it holds nothing
    assign src_req_ready = !burst_valid;

    assign load = src_req_valid && src_req_ready;
    assign take = burst_valid && burst_ready;

    always_comb
    begin
        if (load)
        begin
            sel_addr = src_req.addr;
            sel_rem  = req_lines_t'(src_req.len) + 1'b1;
            sel_id   = src_req.id;
        end
        else
        begin
            sel_addr = next_addr;
            sel_rem  = rem_lines;
            sel_id   = burst.id;
        end
        nxt_burst = split(sel_addr, sel_rem, sel_id);
    end

    // Output valid is the only control state, the request is held while it is set
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            burst_valid <= 1'b0;
        else if (load)
            burst_valid <= 1'b1;
        else if (take && burst.last)
            burst_valid <= 1'b0;
    end

    // Load the first burst of a request or step to the next one once taken
    always_ff @(posedge clk)
    begin
        if (load || (take && !burst.last))
        begin
            burst     <= nxt_burst;
            next_addr <= sel_addr + line_addr_t'(nxt_burst.lines);
            rem_lines <= sel_rem - req_lines_t'(nxt_burst.lines);
        end
    end

endmodule

`default_nettype wire

// File: source/rsp_credits.sv
// Response credit gate
// Holds bursts until the reorder buffer has room and hands out slot tags
`default_nettype none

module rsp_credits
    import host_mem_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire burst_t burst,
    input  wire logic   burst_valid,
    output logic        burst_ready,
    output host_req_t   host_req,
    output logic        host_req_valid,
    output logic        alloc_valid,
    output rob_idx_t    alloc_tag,
    output burst_len_t  alloc_lines,
    output src_id_t     alloc_id,
    output logic        alloc_last,
    input  wire logic   release_valid
);

    // Free reorder buffer slots and the slot that the next burst starts at
    credit_t  credits;
    rob_idx_t alloc_idx;

    logic    take;
    credit_t used;

    // A burst passes only when every one of its lines has a free slot
    assign burst_ready = (credits >= credit_t'(burst.lines));
    assign take        = burst_valid && burst_ready;
    assign used        = take ? credit_t'(burst.lines) : '0;

    // The host has no flow control, so the burst goes out in the cycle it is accepted
    assign host_req_valid = take;
    assign host_req       = '{addr: burst.addr, len: burst.len, tag: alloc_idx};

    // The same burst reserves its slots in the reorder buffer
    assign alloc_valid = take;
    assign alloc_tag   = alloc_idx;
    assign alloc_lines = burst.lines;
    assign alloc_id    = burst.id;
    assign alloc_last  = burst.last;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            credits   <= credit_t'(ROB_ENTRIES);
            alloc_idx <= '0;
        end
        else
        begin
            // A drained line may return a credit in the same cycle a burst consumes some
            credits <= credits - used + credit_t'(release_valid);
            // Slot indices wrap naturally at the reorder buffer depth
            if (take)
                alloc_idx <= alloc_idx + rob_idx_t'(burst.lines);
        end
    end

endmodule

`default_nettype wire

// File: source/rd_rob.sv
// Read reorder buffer
// Collects host line responses by slot and returns them to the source in order
`default_nettype none

module rd_rob
    import host_mem_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       alloc_valid,
    input  wire rob_idx_t   alloc_tag,
    input  wire burst_len_t alloc_lines,
    input  wire src_id_t    alloc_id,
    input  wire logic       alloc_last,
    input  wire host_rsp_t  host_rsp,
    input  wire logic       host_rsp_valid,
    output src_rsp_t        src_rsp,
    output logic            src_rsp_valid,
    output logic            release_valid
);

    // Per slot payload written at allocation and on the host response
    line_data_t slot_data [ROB_ENTRIES];
    src_id_t    slot_id   [ROB_ENTRIES];
    logic       slot_last [ROB_ENTRIES];

    // A set bit marks a slot whose data has arrived but not yet drained
    logic [ROB_ENTRIES-1:0] slot_filled;

    // Oldest allocated slot, the next one to be returned
    rob_idx_t head;

    logic drain;

    // The head drains as soon as its data is present, one line per cycle
    assign drain = slot_filled[head];

    assign src_rsp_valid = drain;
    assign src_rsp       = '{id: slot_id[head], data: slot_data[head], last: slot_last[head]};

    // Every drained line frees one slot back to the credit gate
    assign release_valid = drain;

    // Allocation stamps the request id on every slot of the burst
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < HOST_BURST_LINES; i++)
        begin
            if (alloc_valid && (burst_len_t'(i) < alloc_lines))
            begin
                slot_id[alloc_tag + rob_idx_t'(i)] <= alloc_id;
                // Only the final line of the final burst closes the source request
                slot_last[alloc_tag + rob_idx_t'(i)] <=
                    alloc_last && (burst_len_t'(i) == alloc_lines - 1'b1);
            end
        end
    end

    // Host data lands in its slot in whatever order it arrives
    always_ff @(posedge clk)
    begin
        if (host_rsp_valid)
            slot_data[host_rsp.tag] <= host_rsp.data;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            slot_filled <= '0;
            head        <= '0;
        end
        else
        begin
            if (drain)
            begin
                slot_filled[head] <= 1'b0;
                head              <= head + 1'b1;
            end
            // Credits keep the host off any slot that is still filled,
            // so this never targets the slot draining in the same cycle
            if (host_rsp_valid)
                slot_filled[host_rsp.tag] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/host_mem_map.sv
// Host memory read port adapter
// Chains burst mapping, credit gating and response reordering
`default_nettype none

module host_mem_map
    import host_mem_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire src_req_t  src_req,
    input  wire logic      src_req_valid,
    output logic           src_req_ready,
    output src_rsp_t       src_rsp,
    output logic           src_rsp_valid,
    output host_req_t      host_req,
    output logic           host_req_valid,
    input  wire host_rsp_t host_rsp,
    input  wire logic      host_rsp_valid
);

    // Aligned bursts on their way to the credit gate
    burst_t burst;
    logic   burst_valid;
    logic   burst_ready;

    // Slot reservation from the credit gate into the reorder buffer
    logic       alloc_valid;
    rob_idx_t   alloc_tag;
    burst_len_t alloc_lines;
    src_id_t    alloc_id;
    logic       alloc_last;

    // One credit returned for each line handed back to the source
    logic release_valid;

    // Cut requests into bursts that stay inside aligned host blocks
    burst_mapper mapper
    (
        .clk, .rst_n,
        .src_req, .src_req_valid, .src_req_ready,
        .burst, .burst_valid, .burst_ready
    );

    // The host port has no flow control, so bursts wait here for buffer space
    rsp_credits credits
    (
        .clk, .rst_n,
        .burst, .burst_valid, .burst_ready,
        .host_req, .host_req_valid,
        .alloc_valid, .alloc_tag, .alloc_lines, .alloc_id, .alloc_last,
        .release_valid
    );

    // Sort out-of-order host lines back into request order
    rd_rob rob
    (
        .clk, .rst_n,
        .alloc_valid, .alloc_tag, .alloc_lines, .alloc_id, .alloc_last,
        .host_rsp, .host_rsp_valid,
        .src_rsp, .src_rsp_valid,
        .release_valid
    );

endmodule

`default_nettype wire

// File: test/host_mem_model.sv
// Host memory model
// Queues the lines of each host burst and answers them one per cycle in a shuffled order
`default_nettype none

module host_mem_model
    import host_mem_pkg::*;
(
    input  wire logic      clk,
    input  wire host_req_t host_req,
    input  wire logic      host_req_valid,
    output host_rsp_t      host_rsp,
    output logic           host_rsp_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // One line that the host still owes, with its reorder buffer slot
    typedef struct packed {
        rob_idx_t   tag;
        line_addr_t addr;
    } pend_line_t;

    pend_line_t  pending[$];
    logic [31:0] rnd_state = 32'd81;

    // Line data is a fixed hash of the line address, so the checker can predict it
    function automatic line_data_t mix_data(line_addr_t addr);
        logic [31:0] h;
        h = {6'd0, addr} * 32'h9e37_79b9;
        return {h, 6'h2d, addr};
    endfunction

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial
    begin
        host_rsp       = '0;
        host_rsp_valid = 1'b0;
    end

    // The adapter's host request only changes on the rising edge, so it is stable here
    always @(negedge clk)
    begin
        pend_line_t p;
        int         pick;
        if (host_req_valid)
        begin
            for (int i = 0; i <= int'(host_req.len); i++)
            begin
                p.tag  = host_req.tag + rob_idx_t'(i);
                p.addr = host_req.addr + line_addr_t'(i);
                pending.push_back(p);
            end
        end
        host_rsp_valid = 1'b0;
        // Any owed line may come back next, across bursts and requests alike
        if (pending.size() > 0)
        begin
            rnd_state      = lcg_next(rnd_state);
            pick           = int'(rnd_state[30:16]) % pending.size();
            host_rsp.tag   = pending[pick].tag;
            host_rsp.data  = mix_data(pending[pick].addr);
            host_rsp_valid = 1'b1;
            pending.delete(pick);
        end
    end

endmodule

`default_nettype wire

// File: test/tb_host_mem_map.sv
// Testbench for the host memory read port adapter
// Random read requests against a shuffling host, checked against an in-order reference
`default_nettype none

module tb_host_mem_map
    import host_mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_REQS = 60;
    // Every request at its longest and 8 cycles for each of its lines
    localparam int MAX_CYCLES = NUM_REQS * 16 * 8;

    logic      clk = 1'b0;
    logic      rst_n;
    src_req_t  src_req;
    logic      src_req_valid;
    logic      src_req_ready;
    src_rsp_t  src_rsp;
    logic      src_rsp_valid;
    host_req_t host_req;
    logic      host_req_valid;
    host_rsp_t host_rsp;
    logic      host_rsp_valid;

    // Expected source lines in order and expected host bursts in issue order
    src_rsp_t    exp_rsp[$];
    host_req_t   exp_burst[$];
    logic [31:0] rnd_state = 32'd81;
    rob_idx_t    next_tag = '0;
    int outstanding = 0;
    int rsp_count = 0;
    int line_total = 0;
    int cycles = 0;
    int rsp_errs = 0;
    int burst_errs = 0;
    int credit_errs = 0;
    int reset_errs = 0;

    host_mem_map uut
    (
        .clk, .rst_n,
        .src_req, .src_req_valid, .src_req_ready,
        .src_rsp, .src_rsp_valid,
        .host_req, .host_req_valid,
        .host_rsp, .host_rsp_valid
    );

    host_mem_model host (.clk, .host_req, .host_req_valid, .host_rsp, .host_rsp_valid);

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Same address hash that the host model puts on every line
    function automatic line_data_t mix_data(line_addr_t addr);
        logic [31:0] h;
        h = {6'd0, addr} * 32'h9e37_79b9;
        return {h, 6'h2d, addr};
    endfunction

    task automatic check_src_rsp(src_rsp_t got, src_rsp_t exp);
        if (got !== exp)
        begin
            $display("ERR %0t: source line id %h data %h last %b, expected id %h data %h last %b",
                     $time, got.id, got.data, got.last, exp.id, exp.data, exp.last);
            rsp_errs++;
        end
    endtask

    task automatic check_host_req(host_req_t got, host_req_t exp);
        if (got !== exp)
        begin
            $display("ERR %0t: burst addr %h len %0d tag %0d, expected addr %h len %0d tag %0d",
                     $time, got.addr, got.len, got.tag, exp.addr, exp.len, exp.tag);
            burst_errs++;
        end
    endtask

    task automatic check_level(logic got, logic exp, string what);
        if (got !== exp)
        begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            reset_errs++;
        end
    endtask

    // One closing line with every error count
    task automatic show_error_counts();
        $display("errors: response %0d, burst %0d, credit %0d, reset %0d",
                 rsp_errs, burst_errs, credit_errs, reset_errs);
    endtask

    // Lines come back in request order and bursts stop at the request end or the block end
    task automatic expect_request(src_req_t req);
        src_rsp_t   r;
        host_req_t  b;
        line_addr_t addr;
        req_lines_t rem;
        burst_len_t lines;
        for (int k = 0; k <= int'(req.len); k++)
        begin
            r.id   = req.id;
            r.data = mix_data(req.addr + line_addr_t'(k));
            r.last = (k == int'(req.len));
            exp_rsp.push_back(r);
        end
        addr = req.addr;
        rem  = req_lines_t'(req.len) + 1'b1;
        line_total += int'(rem);
        while (rem != 0)
        begin
            lines = burst_len_t'(HOST_BURST_LINES - int'(addr % HOST_BURST_LINES));
            if (int'(rem) < int'(lines))
                lines = burst_len_t'(rem);
            // Slots are handed out back to back and wrap at the buffer depth
            b.addr = addr;
            b.len  = lines - 1'b1;
            b.tag  = next_tag;
            exp_burst.push_back(b);
            next_tag += rob_idx_t'(lines);
            addr += line_addr_t'(lines);
            rem -= req_lines_t'(lines);
        end
    endtask

    initial
    begin
        src_req_t   req;
        logic [2:0] gap;
        rst_n         = 1'b0;
        src_req       = '0;
        src_req_valid = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        for (int n = 0; n < NUM_REQS; n++)
        begin
            rnd_state = lcg_next(rnd_state);
            req.addr  = rnd_state[31:6];
            rnd_state = lcg_next(rnd_state);
            req.len   = rnd_state[19:16];
            req.id    = rnd_state[23:20];
            gap       = rnd_state[26:24];
            repeat (gap) @(negedge clk);
            src_req       = req;
            src_req_valid = 1'b1;
            // Ready comes from a register, so it holds until the next rising edge
            while (!src_req_ready)
                @(negedge clk);
            expect_request(req);
            @(negedge clk);
            src_req_valid = 1'b0;
        end
        while (exp_rsp.size() != 0)
            @(negedge clk);
        // A few quiet cycles catch any surplus line or burst
        repeat (20) @(negedge clk);
        if (rsp_count != line_total || exp_burst.size() != 0)
        begin
            $display("ERR %0t: %0d source lines of %0d, %0d host bursts never issued",
                     $time, rsp_count, line_total, exp_burst.size());
            rsp_errs++;
        end
        show_error_counts();
        if (rsp_errs + burst_errs + credit_errs + reset_errs == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // All adapter outputs come from registers, so the falling edge sees settled values
    always @(negedge clk)
    begin
        cycles++;
        // The first four falling edges fall inside reset or right at its release
        if (cycles <= 4)
        begin
            check_level(src_rsp_valid, 1'b0, "src_rsp_valid during reset");
            check_level(host_req_valid, 1'b0, "host_req_valid during reset");
            check_level(src_req_ready, 1'b1, "src_req_ready during reset");
        end
        if (host_req_valid)
        begin
            if (exp_burst.size() == 0)
            begin
                $display("ERR %0t: host burst addr %h with none expected", $time, host_req.addr);
                burst_errs++;
            end
            else
                check_host_req(host_req, exp_burst.pop_front());
            outstanding += int'(host_req.len) + 1;
        end
        if (src_rsp_valid)
        begin
            if (exp_rsp.size() == 0)
            begin
                $display("ERR %0t: source line id %h with none expected", $time, src_rsp.id);
                rsp_errs++;
            end
            else
                check_src_rsp(src_rsp, exp_rsp.pop_front());
            rsp_count++;
            outstanding--;
        end
        // Lines in flight may never outgrow the reorder buffer
        if (outstanding > ROB_ENTRIES)
        begin
            $display("ERR %0t: %0d lines in flight, limit %0d", $time, outstanding, ROB_ENTRIES);
            credit_errs++;
        end
        if (cycles >= MAX_CYCLES)
        begin
            $display("Responses stopped arriving, only %0d of %0d lines came back in %0d cycles",
                     rsp_count, line_total, cycles);
            show_error_counts();
            $display("Test failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: all.f
source/host_mem_pkg.sv
source/burst_mapper.sv
source/rsp_credits.sv
source/rd_rob.sv
source/host_mem_map.sv
test/host_mem_model.sv
test/tb_host_mem_map.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the host memory adapter testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_host_mem_map -f all.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
